// File: tests/allocPatterns.txt
// Columns: req[4:0] (S W E N L), flit L, N, E, W, S, expected grant, outValid, outFlit.
// Flit word is id[30:28], length[27:16], data[15:0]; data holds port digit and line.
// Full load from idle, header limits L 2, N 0, E 1, W 0, S 5.
1F 10021000 10002000 10013000 10004000 10055000 02 0 00000000
1F 20001001 20002001 20003001 20004001 20005001 02 1 20001001
1F 20001002 20002002 20003002 20004002 20005002 02 1 20001002
1F 20001003 20002003 20003003 20004003 20005003 04 1 20001003
1F 20001004 20002004 20003004 20004004 20005004 08 1 20002004
1F 20001005 20002005 20003005 20004005 20005005 08 1 20003005
1F 20001006 20002006 20003006 20004006 20005006 10 1 20003006
1F 20001007 20002007 20003007 20004007 20005007 20 1 20004007
1F 20001008 20002008 20003008 20004008 20005008 20 1 20005008
1F 20001009 20002009 20003009 20004009 20005009 20 1 20005009
1F 2000100A 2000200A 2000300A 2000400A 2000500A 20 1 2000500A
1F 2000100B 2000200B 2000300B 2000400B 2000500B 20 1 2000500B
1F 2000100C 2000200C 2000300C 2000400C 2000500C 20 1 2000500C
1F 2000100D 2000200D 2000300D 2000400D 2000500D 02 1 2000500D
// Local drops early, North regains alone, then idle.
03 2000100E 2000200E 2000300E 2000400E 2000500E 02 1 2000100E
02 2000100F 2000200F 2000300F 2000400F 2000500F 04 0 2000100F
02 20001010 20002010 20003010 20004010 20005010 04 1 20002010
00 20001011 20002011 20003011 20004011 20005011 01 0 20002011
00 20001012 20002012 20003012 20004012 20005012 01 0 00000000
// East with limit 4 releases after two cycles.
04 20001013 20002013 10043013 20004013 20005013 08 0 00000000
04 20001014 20002014 20003014 20004014 20005014 08 1 20003014
00 20001015 20002015 20003015 20004015 20005015 01 0 20003015
00 20001016 20002016 20003016 20004016 20005016 01 0 00000000
// New limits on every port, East first, then W, S, L, N.
04 10001017 10002017 10013017 10004017 10005017 08 0 00000000
1F 20001018 20002018 20003018 20004018 20005018 08 1 20003018
1F 20001019 20002019 20003019 20004019 20005019 10 1 20003019
1F 2000101A 2000201A 2000301A 2000401A 2000501A 20 1 2000401A
1F 2000101B 2000201B 2000301B 2000401B 2000501B 02 1 2000501B
1F 2000101C 2000201C 2000301C 2000401C 2000501C 04 1 2000101C
// East alone regains after expiry, then shares with West.
04 2000101D 2000201D 2000301D 2000401D 2000501D 08 0 2000201D
04 2000101E 2000201E 2000301E 2000401E 2000501E 08 1 2000301E
04 2000101F 2000201F 2000301F 2000401F 2000501F 08 1 2000301F
04 20001020 20002020 20003020 20004020 20005020 08 1 20003020
0C 20001021 20002021 20003021 20004021 20005021 10 1 20003021
0C 20001022 20002022 20003022 20004022 20005022 08 1 20004022
00 20001023 20002023 20003023 20004023 20005023 01 0 20003023
// From East with only L and N asking, Local comes first.
04 20001024 20002024 10003024 20004024 20005024 08 0 00000000
03 20001025 20002025 20003025 20004025 20005025 02 0 20003025
03 20001026 20002026 20003026 20004026 20005026 04 1 20001026
00 20001027 20002027 20003027 20004027 20005027 01 0 20002027
00 20001028 20002028 20003028 20004028 20005028 01 0 00000000

// File: vlog.f
src/nocPkg.sv
src/holdTimer.sv
src/switchArbiter.sv
src/flitMux.sv
src/outputAllocator.sv
tests/outputAllocatorTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module outputAllocatorTb -o outputAllocatorSim

simOut=$(./obj_dir/outputAllocatorSim)
echo "$simOut"

if echo "$simOut" | grep -q "^all tests passed$"
then
  exit 0
fi
exit 1

// File: tests/outputAllocatorTb.sv
`timescale 1ns/1ps

module outputAllocatorTb
  import nocPkg::*;
();

  localparam int clkPeriod     = 10;
  localparam int numPatterns   = 41;
  localparam int wordsPerLine  = 9;
  localparam int numWords      = numPatterns * wordsPerLine;
  localparam int timeoutCycles = numPatterns + 20;

  // Expected DUT response for one pattern line.
  typedef struct packed {
    grantT grant;
    logic  valid;
    flitT  flit;
  } expectT;

  logic                clk;
  logic                rst;
  flitT                inFlit [numPorts];
  logic [numPorts-1:0] req;
  grantT               grant;
  flitT                outFlit;
  logic                outValid;

  logic [31:0] patMem [numWords];

  int loadErrors;
  int grantErrors;
  int validErrors;
  int flitErrors;

  outputAllocator u_outputAllocator (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .req      (req),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  // Word 0 of a line is req, words 1 to 5 are the port flits.
  function automatic logic [numPorts-1:0] reqAt(input int line);
    return patMem[line * wordsPerLine][numPorts-1:0];
  endfunction

  function automatic flitT flitAt(input int line, input int port);
    return patMem[line * wordsPerLine + 1 + port][$bits(flitT)-1:0];
  endfunction

  function automatic expectT expectedAt(input int line);
    expectT want;
    int     base;
    base = line * wordsPerLine;
    want.grant = patMem[base + 6][numPorts:0];
    want.valid = patMem[base + 7][0];
    want.flit = patMem[base + 8][$bits(flitT)-1:0];
    return want;
  endfunction

  task automatic checkResponse(input int line, input expectT want);
    if (grant !== want.grant)
    begin
      grantErrors++;
      $display("Error at %0t, line %0d: grant expected %h, got %h",
               $time, line, want.grant, grant);
    end
    if (outValid !== want.valid)
    begin
      validErrors++;
      $display("Error at %0t, line %0d: outValid expected %b, got %b",
               $time, line, want.valid, outValid);
    end
    if (outFlit !== want.flit)
    begin
      flitErrors++;
      $display("Error at %0t, line %0d: outFlit expected %h, got %h",
               $time, line, want.flit, outFlit);
    end
  endtask

  initial
  begin
    expectT resetState;
    rst = 1'b1;
    req = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p] = '0;
    end
    loadErrors = 0;
    grantErrors = 0;
    validErrors = 0;
    flitErrors = 0;
    resetState.grant = grantIdle;
    resetState.valid = 1'b0;
    resetState.flit = '0;

    $readmemh("tests/allocPatterns.txt", patMem);
    if ($isunknown(patMem[numWords - 1]))
    begin
      loadErrors++;
      $display("Pattern file tests/allocPatterns.txt is missing or too short");
    end

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    req <= reqAt(0);
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p] <= flitAt(0, p);
    end
    @(negedge clk);
    checkResponse(-1, resetState);

    // Line n is applied at one edge and its response is checked after the next.
    for (int n = 0; n < numPatterns; n++)
    begin
      @(posedge clk);
      if (n + 1 < numPatterns)
      begin
        req <= reqAt(n + 1);
        for (int p = 0; p < numPorts; p++)
        begin
          inFlit[p] <= flitAt(n + 1, p);
        end
      end
      else
      begin
        req <= '0;
        for (int p = 0; p < numPorts; p++)
        begin
          inFlit[p] <= '0;
        end
      end
      @(negedge clk);
      checkResponse(n, expectedAt(n));
    end

    $display("Errors: pattern file %0d, grant %0d, outValid %0d, outFlit %0d",
             loadErrors, grantErrors, validErrors, flitErrors);
    if (loadErrors + grantErrors + validErrors + flitErrors == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

  initial
  begin
    repeat (timeoutCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
    $display("tests failed");
    $finish;
  end

endmodule

// File: src/outputAllocator.sv
`timescale 1ns/1ps

module outputAllocator
  import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitT                inFlit [numPorts],
  input  logic [numPorts-1:0] req,
  output grantT               grant,
  output flitT                outFlit,
  output logic                outValid
);

  // Grant state also drives the multiplexer select.
  switchArbiter u_switchArbiter (
    .clk    (clk),
    .rst    (rst),
    .inFlit (inFlit),
    .req    (req),
    .grant  (grant)
  );

  flitMux u_flitMux (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .req      (req),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// File: src/flitMux.sv
`timescale 1ns/1ps

module flitMux
  import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitT                inFlit [numPorts],
  input  logic [numPorts-1:0] req,
  input  grantT               grant,
  output flitT                outFlit,
  output logic                outValid
);

  flitT selFlit;
  logic selValid;

  // One-hot AND-OR select, bit 0 of grant (idle) selects nothing.
  always_comb
  begin
    selFlit = '0;
    selValid = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      selFlit = selFlit | (inFlit[p] & {$bits(flitT){grant[p + 1]}});
      selValid = selValid | (req[p] & grant[p + 1]);
    end
  end

  // Output lags the grant by one cycle.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit <= selFlit;
      outValid <= selValid;
    end
  end

endmodule

// File: src/switchArbiter.sv
`timescale 1ns/1ps

module switchArbiter
  import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitT                inFlit [numPorts],
  input  logic [numPorts-1:0] req,
  output grantT               grant
);

  grantT               nextGrant;
  logic [numPorts-1:0] run;
  logic [numPorts-1:0] timesUp;

  // One-hot state for a port index.
  function automatic grantT portGrant(input int port);
    grantT g;
    g = '0;
    g[port + 1] = 1'b1;
    return g;
  endfunction

  // First requester after port last in circular order, last itself checked last.
  function automatic grantT rotate(input int last, input logic [numPorts-1:0] reqs);
    grantT g;
    int    idx;
    g = grantIdle;
    // Walk backwards so the nearest requester is the one kept.
    for (int i = numPorts; i >= 1; i--)
    begin
      idx = (last + i) % numPorts;
      if (reqs[idx])
      begin
        g = portGrant(idx);
      end
    end
    return g;
  endfunction

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    holdTimer u_holdTimer (
      .clk     (clk),
      .rst     (rst),
      .flitId  (inFlit[p].id),
      .length  (inFlit[p].length),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= grantIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  always_comb
  begin
    run = '0;
    nextGrant = grantIdle;
    case (grant)
      // From idle the order is L, N, E, W, S, same as the order after South.
      grantIdle:
      begin
        nextGrant = rotate(portS, req);
      end
      portGrant(portL):
      begin
        if (req[portL] && !timesUp[portL])
        begin
          run[portL] = 1'b1;
          nextGrant = grant;
        end
        else
        begin
          nextGrant = rotate(portL, req);
        end
      end
      portGrant(portN):
      begin
        if (req[portN] && !timesUp[portN])
        begin
          run[portN] = 1'b1;
          nextGrant = grant;
        end
        else
        begin
          nextGrant = rotate(portN, req);
        end
      end
      // After East come West, South, Local, North, then East again.
      portGrant(portE):
      begin
        if (req[portE] && !timesUp[portE])
        begin
          run[portE] = 1'b1;
          nextGrant = grant;
        end
        else
        begin
          nextGrant = rotate(portE, req);
        end
      end
      portGrant(portW):
      begin
        if (req[portW] && !timesUp[portW])
        begin
          run[portW] = 1'b1;
          nextGrant = grant;
        end
        else
        begin
          nextGrant = rotate(portW, req);
        end
      end
      portGrant(portS):
      begin
        if (req[portS] && !timesUp[portS])
        begin
          run[portS] = 1'b1;
          nextGrant = grant;
        end
        else
        begin
          nextGrant = rotate(portS, req);
        end
      end
      // Not one-hot, recover through idle.
      default:
      begin
        nextGrant = grantIdle;
      end
    endcase
  end

endmodule

// File: src/holdTimer.sv
`timescale 1ns/1ps

module holdTimer
  import nocPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [flitIdWidth-1:0] flitId,
  input  logic [lengthWidth-1:0] length,
  input  logic                   run,
  output logic                   timesUp
);

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Any header flit on this port sets the limit, granted or not.
      if (flitId == flitHeader)
      begin
        limit <= length;
      end

      // Count restarts each time the grant is lost.
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // Held for limit plus one cycles when the port keeps requesting.
  assign timesUp = (count == limit);

endmodule

// File: src/nocPkg.sv
package nocPkg;

  // Router ports.
  localparam int numPorts = 5;

  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  // Flit field widths.
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;
  localparam int dataWidth   = 16;

  // Flit id codes.
  localparam logic [flitIdWidth-1:0] flitHeader = 3'd1;
  localparam logic [flitIdWidth-1:0] flitBody   = 3'd2;
  localparam logic [flitIdWidth-1:0] flitTail   = 3'd3;

  // One-hot switch state.
  // Bit 0 is idle, bits 1 to 5 follow the port indices shifted up by one.
  typedef logic [numPorts:0] grantT;

  localparam grantT grantIdle = grantT'(1);

  // Length is only meaningful when id is flitHeader.
  typedef struct packed {
    logic [flitIdWidth-1:0] id;
    logic [lengthWidth-1:0] length;
    logic [dataWidth-1:0]   data;
  } flitT;

endpackage
